// File: sim.f
rtl/ddr_types_pkg.sv
rtl/ddr_calib.sv
rtl/ddr_axi_slave.sv
rtl/ddr_mem_array.sv
rtl/ddr_apb_regs.sv
rtl/ddr_inferred.sv
rtl/ddr_tech.sv
testbench/tb_ddr_tech.sv

// File: Makefile
SRCS := $(shell cat sim.f)

obj_dir/Vtb_ddr_tech: sim.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_ddr_tech -f sim.f

.PHONY: run clean

run: obj_dir/Vtb_ddr_tech testbench/ddr_testdata.txt
	./obj_dir/Vtb_ddr_tech

clean:
	rm -rf obj_dir

// File: testbench/ddr_testdata.txt
# op addr data strb exp_data exp_resp, all hex; exp_resp is AXI resp or APB pslverr
# W/R AXI write/read, A/B APB read/write, C wait for calibration done
A 00001000 0 00 0 0
C 00000000 0 00 0 0
A 00001000 0 00 1 0
W 80000000 0f1e2d3c4b5a6978 ff 0 0
W 80000010 1122334455667788 ff 0 0
R 80000010 0 00 1122334455667788 0
W 80000010 aabbccddeeff0011 0f 0 0
R 80000010 0 00 11223344eeff0011 0
W 80000018 ffeeddccbbaa9988 ff 0 0
W 80000018 0102030405060708 a5 0 0
R 80000018 0 00 01ee03ccbb069908 0
W 800007f8 0123456789abcdef ff 0 0
R 800007f8 0 00 0123456789abcdef 0
W 80000800 deadbeefdeadbeef ff 0 2
R 80000800 0 00 0 2
R 7ffffff8 0 00 0 2
R 80000000 0 00 0f1e2d3c4b5a6978 0
A 00001004 0 00 7 0
A 00001008 0 00 7 0
A 0000100c 0 00 3 0
A 00001014 0 00 0 1
B 00001010 1 00 0 0
A 00001004 0 00 0 0
A 00001008 0 00 0 0
A 0000100c 0 00 0 0
B 00001020 0 00 0 1

// File: testbench/tb_ddr_tech.sv
`default_nettype none

module tb_ddr_tech;

    timeunit 1ns;
    timeprecision 1ps;

    // Window bases and the 2 KB AXI window size
    localparam logic [31:0] AXI_BASE = 32'h8000_0000;
    localparam logic [31:0] APB_BASE = 32'h0000_1000;
    localparam logic [31:0] WINDOW_BYTES = 32'(ddr_types_pkg::MEM_WORDS * 8);
    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic clk;
    logic rst_n;
    ddr_types_pkg::mapinfo_type xmapinfo;
    ddr_types_pkg::axi4_slave_in_type xslvi;
    ddr_types_pkg::axi4_slave_out_type xslvo;
    ddr_types_pkg::mapinfo_type pmapinfo;
    ddr_types_pkg::apb_in_type apbi;
    ddr_types_pkg::apb_out_type apbo;
    logic ui_nrst;
    logic init_calib_done;

    // Back-pressure source
    integer seed;

    // Reference memory, plus which bytes of each word were written
    logic [63:0] ref_mem [256];
    logic [7:0] ref_wr [256];

    // Expected statistics
    int wr_tally;
    int rd_tally;
    int err_tally;

    int clocks_after_reset;
    int calib_rise_clock = -1;

    ddr_tech ddr_tech_inst
    (
        .i_xslv_clk(clk),
        .i_rst_n(rst_n),
        .i_xmapinfo(xmapinfo),
        .i_xslvi(xslvi),
        .o_xslvo(xslvo),
        .i_pmapinfo(pmapinfo),
        .i_apbi(apbi),
        .o_apbo(apbo),
        .o_ui_nrst(ui_nrst),
        .o_init_calib_done(init_calib_done)
    );

    always #50 clk = ~clk;

    // Rising edges seen since reset release
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            clocks_after_reset <= 0;
        else
            clocks_after_reset <= clocks_after_reset + 1;
    end

    // Edge count at which calibration done first shows up
    always @(negedge clk)
    begin
        if (rst_n && init_calib_done && (calib_rise_clock < 0))
            calib_rise_clock = clocks_after_reset;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
            fail_run($sformatf("Error at %0d ns: %s is %h, expected %h",
                               $time, what, actual, expected));
    endtask

    // Inputs change 5 ns after the rising edge
    task automatic next_drive();
        @(posedge clk);
        #5;
    endtask

    task automatic shake_ready();
        logic [31:0] r;
        r = $random(seed);
        xslvi.b_ready = r[0];
        xslvi.r_ready = r[1];
    endtask

    function automatic logic [63:0] strobe_mask(input logic [7:0] strb);
        logic [63:0] m;
        for (int i = 0; i < 8; i++)
            m[8*i +: 8] = {8{strb[i]}};
        return m;
    endfunction

    // Wait for b or r, check it holds still until ready, and that only one arrives
    task automatic take_response(input logic is_read, input int exp_lat,
                                 output logic [63:0] data, output logic [1:0] resp,
                                 output logic [3:0] id);
        int lat;
        logic seen;
        logic taken;
        logic valid;
        logic other;
        logic ready;
        logic [69:0] cur;
        logic [69:0] first;
        lat = 0;
        seen = 1'b0;
        taken = 1'b0;
        first = '0;
        while (!taken)
        begin
            @(negedge clk);
            lat++;
            if (is_read)
            begin
                valid = xslvo.r_valid;
                other = xslvo.b_valid;
                ready = xslvi.r_ready;
                cur = {xslvo.r_resp, xslvo.r_id, xslvo.r_data};
            end
            else
            begin
                valid = xslvo.b_valid;
                other = xslvo.r_valid;
                ready = xslvi.b_ready;
                cur = {xslvo.b_resp, xslvo.b_id, 64'd0};
            end
            check_value(64'(other), 64'd0, "valid on the other response channel");
            if (seen)
            begin
                check_value(64'(valid), 64'd1, "valid held until ready");
                check_value(cur[63:0], first[63:0], "data held until ready");
                check_value(64'(cur[69:64]), 64'(first[69:64]), "resp and id held until ready");
            end
            else if (valid)
            begin
                check_value(64'(lat), 64'(exp_lat), "response latency in clocks");
                seen = 1'b1;
                first = cur;
            end
            taken = valid && ready;
            if (!taken)
            begin
                if (lat > WAIT_LIMIT)
                    fail_run(is_read ? "Timeout: AXI read response was never taken"
                                     : "Timeout: AXI write response was never taken");
                next_drive();
                shake_ready();
            end
        end
        next_drive();
        xslvi.b_ready = 1'b0;
        xslvi.r_ready = 1'b0;
        // Back in idle, nothing more may follow
        @(negedge clk);
        check_value(64'({xslvo.b_valid, xslvo.r_valid}), 64'd0, "valid after response taken");
        {resp, id, data} = first;
    endtask

    // One single-beat AXI transfer with id echo check
    task automatic axi_access(input logic is_read, input logic [31:0] addr,
                              input logic [63:0] wdata, input logic [7:0] strb,
                              input logic [3:0] id, output logic [63:0] rdata,
                              output logic [1:0] resp);
        int waited;
        logic acc;
        logic [3:0] rid;
        next_drive();
        xslvi.b_ready = 1'b0;
        xslvi.r_ready = 1'b0;
        if (is_read)
        begin
            xslvi.ar_valid = 1'b1;
            xslvi.ar_addr = addr;
            xslvi.ar_id = id;
        end
        else
        begin
            xslvi.aw_valid = 1'b1;
            xslvi.aw_addr = addr;
            xslvi.aw_id = id;
            xslvi.w_valid = 1'b1;
            xslvi.w_data = wdata;
            xslvi.w_strb = strb;
        end
        waited = 0;
        acc = 1'b0;
        while (!acc)
        begin
            @(negedge clk);
            acc = is_read ? xslvo.ar_ready : (xslvo.aw_ready && xslvo.w_ready);
            waited++;
            if (!acc && (waited > WAIT_LIMIT))
                fail_run(is_read ? "Timeout: AXI read address was never accepted"
                                 : "Timeout: AXI write address and data were never accepted");
        end
        next_drive();
        xslvi.aw_valid = 1'b0;
        xslvi.w_valid = 1'b0;
        xslvi.ar_valid = 1'b0;
        shake_ready();
        // Write answers one clock later, read two
        take_response(is_read, is_read ? 2 : 1, rdata, resp, rid);
        check_value(64'(rid), 64'(id), "echoed id");
    endtask

    // Setup then access phase, sampled where pready is high
    task automatic apb_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        next_drive();
        apbi.psel = 1'b1;
        apbi.penable = 1'b0;
        apbi.pwrite = write;
        apbi.paddr = addr;
        apbi.pwdata = wdata;
        next_drive();
        apbi.penable = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!apbo.pready)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                fail_run("Timeout: APB access phase never saw pready");
            @(negedge clk);
        end
        rdata = apbo.prdata;
        err = apbo.pslverr;
        next_drive();
        apbi.psel = 1'b0;
        apbi.penable = 1'b0;
        apbi.pwrite = 1'b0;
    endtask

    task automatic check_quiet_outputs(input string when);
        check_value(64'({init_calib_done, ui_nrst, xslvo.aw_ready, xslvo.w_ready,
                         xslvo.ar_ready, xslvo.b_valid, xslvo.r_valid, apbo.pslverr}),
                    64'd0, when);
    endtask

    initial
    begin
        int fd;
        int ops_done;
        int waited;
        string line;
        logic [7:0] op_c;
        logic [31:0] addr;
        logic [31:0] off;
        logic [63:0] data;
        logic [7:0] strb;
        logic [63:0] exp_data;
        logic [1:0] exp_resp;
        logic in_range;
        logic [7:0] idx;
        logic [1:0] want_resp;
        logic [63:0] want_data;
        logic [63:0] got_data;
        logic [1:0] got_resp;
        logic [31:0] prdata;
        logic perr;
        logic [31:0] want_prdata;
        logic want_err;
        seed = 32'h75105515;
        clk = 1'b0;
        rst_n = 1'b0;
        xmapinfo.addr_start = AXI_BASE;
        pmapinfo.addr_start = APB_BASE;
        xslvi = '0;
        apbi = '0;
        wr_tally = 0;
        rd_tally = 0;
        err_tally = 0;
        ops_done = 0;
        for (int i = 0; i < 256; i++)
            ref_wr[i] = 8'h00;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_quiet_outputs("outputs during reset");
        next_drive();
        rst_n = 1'b1;
        @(negedge clk);
        check_quiet_outputs("outputs just after reset release");
        fd = $fopen("testbench/ddr_testdata.txt", "r");
        if (fd == 0)
            fail_run("Cannot open testbench/ddr_testdata.txt");
        while ($fgets(line, fd) != 0)
        begin
            if ((line.len() < 2) || (line[0] == "#"))
                continue;
            if ($sscanf(line, "%c %h %h %h %h %h", op_c, addr, data, strb, exp_data,
                        exp_resp) != 6)
                fail_run({"Malformed test data line: ", line});
            ops_done++;
            if (op_c == "C")
            begin
                waited = 0;
                while (calib_rise_clock < 0)
                begin
                    waited++;
                    if (waited > WAIT_LIMIT)
                        fail_run("Timeout: calibration done never rose");
                    next_drive();
                end
                check_value(64'(calib_rise_clock), 64'(ddr_types_pkg::CALIB_CYCLES),
                            "clock of calibration done rise");
                check_value(64'(ui_nrst), 64'd1, "o_ui_nrst after calibration");
            end
            else if ((op_c == "W") || (op_c == "R"))
            begin
                off = addr - AXI_BASE;
                in_range = off < WINDOW_BYTES;
                idx = off[3 +: 8];
                want_resp = in_range ? 2'b00 : 2'b10;
                want_data = 64'd0;
                if ((op_c == "R") && in_range)
                begin
                    if (ref_wr[idx] != 8'hff)
                        fail_run("Test data reads a word that was never fully written");
                    want_data = ref_mem[idx];
                end
                check_value(exp_data, want_data, "test data expected read data");
                check_value(64'(exp_resp), 64'(want_resp), "test data expected response");
                axi_access(op_c == "R", addr, data, strb, 4'(ops_done), got_data, got_resp);
                check_value(64'(got_resp), 64'(want_resp), "AXI response");
                if (op_c == "R")
                begin
                    check_value(got_data, want_data, "AXI read data");
                    rd_tally++;
                end
                else
                begin
                    wr_tally++;
                    // Merge only strobed bytes
                    if (in_range)
                    begin
                        ref_mem[idx] = (ref_mem[idx] & ~strobe_mask(strb))
                                       | (data & strobe_mask(strb));
                        ref_wr[idx] = ref_wr[idx] | strb;
                    end
                end
                if (!in_range)
                    err_tally++;
            end
            else if ((op_c == "A") || (op_c == "B"))
            begin
                apb_access(op_c == "B", addr, data[31:0], prdata, perr);
                off = addr - APB_BASE;
                want_err = 1'b0;
                want_prdata = 32'd0;
                // One clock has passed since the access phase sample
                case (off)
                    32'h00: want_prdata = 32'((clocks_after_reset - 1)
                                              >= ddr_types_pkg::CALIB_CYCLES);
                    32'h04: want_prdata = 32'(wr_tally);
                    32'h08: want_prdata = 32'(rd_tally);
                    32'h0C: want_prdata = 32'(err_tally);
                    32'h10: want_prdata = 32'd0;
                    default: want_err = 1'b1;
                endcase
                check_value(64'(exp_resp), 64'(want_err), "test data expected pslverr");
                check_value(64'(perr), 64'(want_err), "APB pslverr");
                if (op_c == "A")
                begin
                    check_value(exp_data, 64'(want_prdata), "test data expected prdata");
                    check_value(64'(prdata), 64'(want_prdata), "APB prdata");
                end
                else if ((off == 32'h10) && data[0])
                begin
                    wr_tally = 0;
                    rd_tally = 0;
                    err_tally = 0;
                end
            end
            else
                fail_run({"Unknown operation in test data: ", line});
        end
        $fclose(fd);
        if (ops_done == 0)
            fail_run("No operations found in the test data");
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ddr_tech.sv
`default_nettype none

module ddr_tech
(
    input wire i_xslv_clk,
    input wire i_rst_n,
    // AXI memory window
    input wire ddr_types_pkg::mapinfo_type i_xmapinfo,
    input wire ddr_types_pkg::axi4_slave_in_type i_xslvi,
    output ddr_types_pkg::axi4_slave_out_type o_xslvo,
    // APB control window, same clock as AXI
    input wire ddr_types_pkg::mapinfo_type i_pmapinfo,
    input wire ddr_types_pkg::apb_in_type i_apbi,
    output ddr_types_pkg::apb_out_type o_apbo,
    // Status toward the SoC
    output logic o_ui_nrst,
    output logic o_init_calib_done
);

    // Requests rebased to window offsets
    ddr_types_pkg::axi4_slave_in_type wb_xslvi;
    ddr_types_pkg::apb_in_type wb_apbi;

    // Pure subtraction, no added latency
    always_comb
    begin
        wb_xslvi = i_xslvi;
        wb_xslvi.aw_addr = i_xslvi.aw_addr - i_xmapinfo.addr_start;
        wb_xslvi.ar_addr = i_xslvi.ar_addr - i_xmapinfo.addr_start;

        wb_apbi = i_apbi;
        wb_apbi.paddr = i_apbi.paddr - i_pmapinfo.addr_start;
    end

    // Behavioral controller, the only target built
    ddr_inferred inf0
    (
        .i_xslv_clk(i_xslv_clk),
        .i_rst_n(i_rst_n),
        .i_xslvi(wb_xslvi),
        .o_xslvo(o_xslvo),
        .i_apbi(wb_apbi),
        .o_apbo(o_apbo),
        .o_ui_nrst(o_ui_nrst),
        .o_init_calib_done(o_init_calib_done)
    );

endmodule

`default_nettype wire

// File: rtl/ddr_inferred.sv
`default_nettype none

module ddr_inferred
(
    input wire i_xslv_clk,
    input wire i_rst_n,
    input wire ddr_types_pkg::axi4_slave_in_type i_xslvi,
    output ddr_types_pkg::axi4_slave_out_type o_xslvo,
    input wire ddr_types_pkg::apb_in_type i_apbi,
    output ddr_types_pkg::apb_out_type o_apbo,
    output logic o_ui_nrst,
    output logic o_init_calib_done
);

    // Calibration status shared by both bus blocks
    logic calib_done;

    // RAM request and returned word
    ddr_types_pkg::mem_req_type mem_req;
    logic [ddr_types_pkg::DATA_BITS-1:0] mem_rdata;

    // Statistics pulses from the AXI engine
    logic wr_event;
    logic rd_event;
    logic err_event;

    assign o_init_calib_done = calib_done;

    ddr_calib calib0
    (
        .i_xslv_clk(i_xslv_clk),
        .i_rst_n(i_rst_n),
        .o_calib_done(calib_done),
        .o_ui_nrst(o_ui_nrst)
    );

    ddr_axi_slave axi0
    (
        .i_xslv_clk(i_xslv_clk),
        .i_rst_n(i_rst_n),
        .i_calib_done(calib_done),
        .i_xslvi(i_xslvi),
        .o_xslvo(o_xslvo),
        .o_mem_req(mem_req),
        .i_mem_rdata(mem_rdata),
        .o_wr_event(wr_event),
        .o_rd_event(rd_event),
        .o_err_event(err_event)
    );

    ddr_mem_array mem0
    (
        .i_xslv_clk(i_xslv_clk),
        .i_mem_req(mem_req),
        .o_rdata(mem_rdata)
    );

    ddr_apb_regs apb0
    (
        .i_xslv_clk(i_xslv_clk),
        .i_rst_n(i_rst_n),
        .i_apbi(i_apbi),
        .o_apbo(o_apbo),
        .i_calib_done(calib_done),
        .i_wr_event(wr_event),
        .i_rd_event(rd_event),
        .i_err_event(err_event)
    );

endmodule

`default_nettype wire

// File: rtl/ddr_apb_regs.sv
`default_nettype none

module ddr_apb_regs
(
    input wire i_xslv_clk,
    input wire i_rst_n,
    input wire ddr_types_pkg::apb_in_type i_apbi,
    output ddr_types_pkg::apb_out_type o_apbo,
    input wire i_calib_done,
    input wire i_wr_event,
    input wire i_rd_event,
    input wire i_err_event
);

    // Transaction statistics
    logic [ddr_types_pkg::CNT_BITS-1:0] wr_cnt;
    logic [ddr_types_pkg::CNT_BITS-1:0] rd_cnt;
    logic [ddr_types_pkg::CNT_BITS-1:0] err_cnt;

    // Access phase and decoded clear
    logic access;
    logic clear;
    logic mapped;

    // Increment that sticks at all ones
    function automatic logic [ddr_types_pkg::CNT_BITS-1:0] sat_inc
    (
        input logic [ddr_types_pkg::CNT_BITS-1:0] cnt,
        input logic ev
    );
        sat_inc = (ev && (cnt != '1)) ? cnt + 1'b1 : cnt;
    endfunction

    assign access = i_apbi.psel && i_apbi.penable;
    assign clear = access && i_apbi.pwrite && (i_apbi.paddr == ddr_types_pkg::REG_CTRL)
                   && i_apbi.pwdata[0];

    always_ff @(posedge i_xslv_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_cnt <= '0;
            rd_cnt <= '0;
            err_cnt <= '0;
        end
        else if (clear)
        begin
            // Clear wins over same-cycle events
            wr_cnt <= '0;
            rd_cnt <= '0;
            err_cnt <= '0;
        end
        else
        begin
            wr_cnt <= sat_inc(wr_cnt, i_wr_event);
            rd_cnt <= sat_inc(rd_cnt, i_rd_event);
            err_cnt <= sat_inc(err_cnt, i_err_event);
        end
    end

    // Zero wait states, read data decoded in the access cycle
    always_comb
    begin
        o_apbo = '0;
        o_apbo.pready = 1'b1;
        mapped = 1'b1;
        case (i_apbi.paddr)
            ddr_types_pkg::REG_STATUS: o_apbo.prdata[0] = i_calib_done;
            ddr_types_pkg::REG_WR_CNT: o_apbo.prdata[ddr_types_pkg::CNT_BITS-1:0] = wr_cnt;
            ddr_types_pkg::REG_RD_CNT: o_apbo.prdata[ddr_types_pkg::CNT_BITS-1:0] = rd_cnt;
            ddr_types_pkg::REG_ERR_CNT: o_apbo.prdata[ddr_types_pkg::CNT_BITS-1:0] = err_cnt;
            // Control is write only, reads back zero
            ddr_types_pkg::REG_CTRL: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
        o_apbo.pslverr = access && !mapped;
    end

    // Access phase only inside a selected transfer
    a_penable_psel: assert property (@(posedge i_xslv_clk) disable iff (!i_rst_n)
        i_apbi.penable |-> i_apbi.psel)
        else $error("penable high without psel");

endmodule

`default_nettype wire

// File: rtl/ddr_mem_array.sv
`default_nettype none

module ddr_mem_array
(
    input wire i_xslv_clk,
    input wire ddr_types_pkg::mem_req_type i_mem_req,
    output logic [ddr_types_pkg::DATA_BITS-1:0] o_rdata
);

    // Word storage, undefined until written
    logic [ddr_types_pkg::DATA_BITS-1:0] mem [ddr_types_pkg::MEM_WORDS];

    always_ff @(posedge i_xslv_clk)
    begin
        if (i_mem_req.en)
        begin
            if (i_mem_req.we)
            begin
                // Only strobed bytes change
                for (int i = 0; i < ddr_types_pkg::STRB_BITS; i++)
                begin
                    if (i_mem_req.strb[i])
                        mem[i_mem_req.addr][8*i +: 8] <= i_mem_req.wdata[8*i +: 8];
                end
            end
            else
            begin
                // Read word valid one clock later, held until next read
                o_rdata <= mem[i_mem_req.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/ddr_axi_slave.sv
`default_nettype none

module ddr_axi_slave
(
    input wire i_xslv_clk,
    input wire i_rst_n,
    input wire i_calib_done,
    input wire ddr_types_pkg::axi4_slave_in_type i_xslvi,
    output ddr_types_pkg::axi4_slave_out_type o_xslvo,
    output ddr_types_pkg::mem_req_type o_mem_req,
    input wire [ddr_types_pkg::DATA_BITS-1:0] i_mem_rdata,
    output logic o_wr_event,
    output logic o_rd_event,
    output logic o_err_event
);

    ddr_types_pkg::axi_state_e state;

    // Captured transaction, one in flight
    logic [ddr_types_pkg::ID_BITS-1:0] rsp_id;
    logic rsp_err;
    logic [ddr_types_pkg::MEM_AW-1:0] rd_word;

    // Handshakes accepted this cycle
    logic wr_hs;
    logic rd_hs;
    logic aw_in_range;
    logic ar_in_range;

    // Response taken this cycle
    logic b_done;
    logic r_done;

    assign aw_in_range = i_xslvi.aw_addr < ddr_types_pkg::MEM_BYTES;
    assign ar_in_range = i_xslvi.ar_addr < ddr_types_pkg::MEM_BYTES;

    // Read has priority over a simultaneous write
    assign rd_hs = (state == ddr_types_pkg::ST_IDLE) && i_calib_done && i_xslvi.ar_valid;
    assign wr_hs = (state == ddr_types_pkg::ST_IDLE) && i_calib_done
                   && i_xslvi.aw_valid && i_xslvi.w_valid && !i_xslvi.ar_valid;

    assign b_done = (state == ddr_types_pkg::ST_WRESP) && i_xslvi.b_ready;
    assign r_done = (state == ddr_types_pkg::ST_RRESP) && i_xslvi.r_ready;

    // One pulse per completed transaction
    assign o_wr_event = b_done;
    assign o_rd_event = r_done;
    assign o_err_event = (b_done || r_done) && rsp_err;

    always_ff @(posedge i_xslv_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state <= ddr_types_pkg::ST_IDLE;
        end
        else
        begin
            case (state)
                ddr_types_pkg::ST_IDLE:
                begin
                    if (rd_hs)
                        state <= ddr_types_pkg::ST_RDWAIT;
                    else if (wr_hs)
                        state <= ddr_types_pkg::ST_WRESP;
                end
                ddr_types_pkg::ST_WRESP:
                begin
                    if (i_xslvi.b_ready)
                        state <= ddr_types_pkg::ST_IDLE;
                end
                // RAM data arrives at the end of this cycle
                ddr_types_pkg::ST_RDWAIT:
                begin
                    state <= ddr_types_pkg::ST_RRESP;
                end
                default:
                begin
                    if (i_xslvi.r_ready)
                        state <= ddr_types_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Id, error flag and read word index
    always_ff @(posedge i_xslv_clk)
    begin
        if (rd_hs)
        begin
            rsp_id <= i_xslvi.ar_id;
            rsp_err <= !ar_in_range;
            rd_word <= i_xslvi.ar_addr[ddr_types_pkg::WORD_LSB +: ddr_types_pkg::MEM_AW];
        end
        else if (wr_hs)
        begin
            rsp_id <= i_xslvi.aw_id;
            rsp_err <= !aw_in_range;
        end
    end

    // Write goes to RAM at the handshake edge, read is issued from ST_RDWAIT
    always_comb
    begin
        o_mem_req = '0;
        if (wr_hs)
        begin
            o_mem_req.en = aw_in_range;
            o_mem_req.we = 1'b1;
            o_mem_req.addr = i_xslvi.aw_addr[ddr_types_pkg::WORD_LSB +: ddr_types_pkg::MEM_AW];
            o_mem_req.wdata = i_xslvi.w_data;
            o_mem_req.strb = i_xslvi.w_strb;
        end
        else if (state == ddr_types_pkg::ST_RDWAIT)
        begin
            o_mem_req.en = !rsp_err;
            o_mem_req.addr = rd_word;
        end
    end

    always_comb
    begin
        o_xslvo = '0;
        o_xslvo.aw_ready = wr_hs;
        o_xslvo.w_ready = wr_hs;
        o_xslvo.ar_ready = rd_hs;
        o_xslvo.b_valid = state == ddr_types_pkg::ST_WRESP;
        o_xslvo.b_resp = rsp_err ? ddr_types_pkg::RESP_SLVERR : ddr_types_pkg::RESP_OKAY;
        o_xslvo.b_id = rsp_id;
        o_xslvo.r_valid = state == ddr_types_pkg::ST_RRESP;
        o_xslvo.r_resp = rsp_err ? ddr_types_pkg::RESP_SLVERR : ddr_types_pkg::RESP_OKAY;
        o_xslvo.r_id = rsp_id;
        // RAM output holds while waiting, out of range reads return zero
        if ((state == ddr_types_pkg::ST_RRESP) && !rsp_err)
            o_xslvo.r_data = i_mem_rdata;
    end

    // Write response held until accepted
    a_b_hold: assert property (@(posedge i_xslv_clk) disable iff (!i_rst_n)
        o_xslvo.b_valid && !i_xslvi.b_ready |=> o_xslvo.b_valid && $stable(o_xslvo.b_id))
        else $error("b channel dropped before b_ready");

    // Read data held until accepted
    a_r_hold: assert property (@(posedge i_xslv_clk) disable iff (!i_rst_n)
        o_xslvo.r_valid && !i_xslvi.r_ready |=> o_xslvo.r_valid && $stable(o_xslvo.r_data))
        else $error("r channel dropped before r_ready");

    // Nothing accepted or in flight while calibration is not done
    a_no_early_ready: assert property (@(posedge i_xslv_clk) disable iff (!i_rst_n)
        !i_calib_done |-> state == ddr_types_pkg::ST_IDLE)
        else $error("transaction in flight before calibration done");

endmodule

`default_nettype wire

// File: rtl/ddr_calib.sv
`default_nettype none

module ddr_calib
(
    input wire i_xslv_clk,
    input wire i_rst_n,
    output logic o_calib_done,
    output logic o_ui_nrst
);

    ddr_types_pkg::calib_state_e state;
    // Clocks elapsed since reset release
    logic [ddr_types_pkg::CALIB_CW-1:0] cnt;

    always_ff @(posedge i_xslv_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state <= ddr_types_pkg::CAL_RESET;
            cnt <= '0;
            o_calib_done <= 1'b0;
            o_ui_nrst <= 1'b0;
        end
        else
        begin
            case (state)
                ddr_types_pkg::CAL_RESET:
                begin
                    // First clock after release
                    state <= ddr_types_pkg::CAL_RUN;
                    cnt <= cnt + 1'b1;
                end
                ddr_types_pkg::CAL_RUN:
                begin
                    cnt <= cnt + 1'b1;
                    // Done and user reset release land on clock CALIB_CYCLES
                    if (cnt == ddr_types_pkg::CALIB_LAST)
                    begin
                        state <= ddr_types_pkg::CAL_DONE;
                        o_calib_done <= 1'b1;
                        o_ui_nrst <= 1'b1;
                    end
                end
                default:
                begin
                    // Hold done until the next reset
                    state <= ddr_types_pkg::CAL_DONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/ddr_types_pkg.sv
`default_nettype none

package ddr_types_pkg;

    // Bus widths
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 64;
    localparam int STRB_BITS = 8;
    localparam int ID_BITS = 4;
    localparam int APB_DATA_BITS = 32;

    // RAM geometry, 256 words of 64 bits gives a 2 KB window
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW = 8;
    localparam int WORD_LSB = 3;
    localparam logic [ADDR_BITS-1:0] MEM_BYTES = ADDR_BITS'(MEM_WORDS * STRB_BITS);

    // Calibration length in clocks after reset release
    localparam int CALIB_CYCLES = 64;
    localparam int CALIB_CW = $clog2(CALIB_CYCLES + 1);
    localparam logic [CALIB_CW-1:0] CALIB_LAST = CALIB_CW'(CALIB_CYCLES - 1);

    // Statistics counter width
    localparam int CNT_BITS = 16;

    // APB register map
    localparam logic [ADDR_BITS-1:0] REG_STATUS = 32'h0000_0000;
    localparam logic [ADDR_BITS-1:0] REG_WR_CNT = 32'h0000_0004;
    localparam logic [ADDR_BITS-1:0] REG_RD_CNT = 32'h0000_0008;
    localparam logic [ADDR_BITS-1:0] REG_ERR_CNT = 32'h0000_000C;
    localparam logic [ADDR_BITS-1:0] REG_CTRL = 32'h0000_0010;

    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_WRESP = 2'd1,
        ST_RDWAIT = 2'd2,
        ST_RRESP = 2'd3
    } axi_state_e;

    typedef enum logic [1:0] {
        CAL_RESET = 2'd0,
        CAL_RUN = 2'd1,
        CAL_DONE = 2'd2
    } calib_state_e;

    // Base of a mapped window
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr_start;
    } mapinfo_type;

    // Master to slave
    typedef struct packed {
        logic aw_valid;
        logic [ADDR_BITS-1:0] aw_addr;
        logic [ID_BITS-1:0] aw_id;
        logic w_valid;
        logic [DATA_BITS-1:0] w_data;
        logic [STRB_BITS-1:0] w_strb;
        logic b_ready;
        logic ar_valid;
        logic [ADDR_BITS-1:0] ar_addr;
        logic [ID_BITS-1:0] ar_id;
        logic r_ready;
    } axi4_slave_in_type;

    // Slave to master
    typedef struct packed {
        logic aw_ready;
        logic w_ready;
        logic b_valid;
        axi_resp_e b_resp;
        logic [ID_BITS-1:0] b_id;
        logic ar_ready;
        logic r_valid;
        logic [DATA_BITS-1:0] r_data;
        axi_resp_e r_resp;
        logic [ID_BITS-1:0] r_id;
    } axi4_slave_out_type;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [ADDR_BITS-1:0] paddr;
        logic [APB_DATA_BITS-1:0] pwdata;
    } apb_in_type;

    typedef struct packed {
        logic pready;
        logic [APB_DATA_BITS-1:0] prdata;
        logic pslverr;
    } apb_out_type;

    // One RAM access, word addressed
    typedef struct packed {
        logic en;
        logic we;
        logic [MEM_AW-1:0] addr;
        logic [DATA_BITS-1:0] wdata;
        logic [STRB_BITS-1:0] strb;
    } mem_req_type;

endpackage

`default_nettype wire
